// File: source/hart_mem_consts.svh
`ifndef HART_MEM_CONSTS_SVH
`define HART_MEM_CONSTS_SVH

// width of every address and data word in the memory system
`define XLEN 32

// byte lanes in one word, one mask bit per lane
`define BYTES_PER_WORD 4

// the instruction cache holds 2**4 = 16 one-word lines
`define ICACHE_INDEX_BITS 4

// the data cache holds 2**4 = 16 one-word lines
`define DCACHE_INDEX_BITS 4

// both caches split an address into tag, index and a 2-bit byte offset,
// so the tag is whatever remains above the index
// tag width = XLEN - 2 - INDEX_BITS, which is 30 - INDEX_BITS for 32 bits

`endif

// File: source/hart_mem_pkg.sv
`include "hart_mem_consts.svh"

package hart_mem_pkg;

    // one address or data word on any bus of the memory system
    typedef logic [`XLEN-1:0] word_t;

    // bit n enables byte lane n, that is bits 8n+7 down to 8n
    typedef logic [`BYTES_PER_WORD-1:0] byte_mask_t;

    // access size of a load or store
    // the encoding leaves 2'b11 unused
    typedef enum logic [1:0] {
        LS_BYTE = 2'd0,
        LS_HALF = 2'd1,
        LS_WORD = 2'd2
    } ls_size_e;

    // which cache currently holds the shared external bus
    typedef enum logic [1:0] {
        OWN_NONE   = 2'd0,
        OWN_ICACHE = 2'd1,
        OWN_DCACHE = 2'd2
    } bus_owner_e;

endpackage

// File: source/icache.sv
`timescale 1ns/1ps

`include "hart_mem_consts.svh"

module icache #(
    parameter int INDEX_BITS = `ICACHE_INDEX_BITS
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    // fetch address, held by the requester while busy
    input  hart_mem_pkg::word_t i_addr,
    output hart_mem_pkg::word_t o_inst,
    output logic                o_busy,
    // read-only side of the external bus
    output logic                o_mem_ren,
    output hart_mem_pkg::word_t o_mem_addr,
    input  hart_mem_pkg::word_t i_mem_rdata,
    input  logic                i_mem_ready,
    input  logic                i_mem_valid
);
    localparam int TAG_BITS = 30 - INDEX_BITS;
    localparam int LINES    = 1 << INDEX_BITS;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } state_e;

    state_e                state_q;
    logic [LINES-1:0]      valid_q;
    logic [TAG_BITS-1:0]   tag_q [LINES];
    hart_mem_pkg::word_t   data_q [LINES];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic                  hit;

    // the two byte-offset bits sit below the index
    assign index = i_addr[2 +: INDEX_BITS];
    assign tag   = i_addr[INDEX_BITS+2 +: TAG_BITS];
    assign hit   = valid_q[index] && (tag_q[index] == tag);

    // a hit returns the line in the same cycle with busy low
    assign o_inst = data_q[index];
    assign o_busy = !hit;

    // the strobe is held in S_REQ until the bus accepts it
    assign o_mem_ren  = (state_q == S_REQ);
    assign o_mem_addr = {i_addr[`XLEN-1:2], 2'b00};

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    // any miss on the held address starts a fill
                    if (!hit) begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (i_mem_ready) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // the line turns valid here so the next cycle hits
                    if (i_mem_valid) begin
                        valid_q[index] <= 1'b1;
                        state_q        <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // the returning word lands in the line picked by the held fetch address
    always_ff @(posedge i_clk) begin
        if ((state_q == S_WAIT) && i_mem_valid) begin
            tag_q[index]  <= tag;
            data_q[index] <= i_mem_rdata;
        end
    end

endmodule

// File: source/dcache.sv
`timescale 1ns/1ps

`include "hart_mem_consts.svh"

module dcache #(
    parameter int INDEX_BITS = `DCACHE_INDEX_BITS
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    // request side from the load/store unit, held while busy
    input  logic                     i_req_ren,
    input  logic                     i_req_wen,
    input  hart_mem_pkg::word_t      i_req_addr,
    input  hart_mem_pkg::word_t      i_req_wdata,
    input  hart_mem_pkg::byte_mask_t i_req_mask,
    output hart_mem_pkg::word_t      o_res_rdata,
    output logic                     o_busy,
    // external bus side, routed through the arbiter
    output logic                     o_mem_ren,
    output logic                     o_mem_wen,
    output hart_mem_pkg::word_t      o_mem_addr,
    output hart_mem_pkg::word_t      o_mem_wdata,
    input  hart_mem_pkg::word_t      i_mem_rdata,
    input  logic                     i_mem_ready,
    input  logic                     i_mem_valid
);
    localparam int TAG_BITS = 30 - INDEX_BITS;
    localparam int LINES    = 1 << INDEX_BITS;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FILL_REQ,
        S_FILL_WAIT,
        S_WRITE,
        S_DONE
    } state_e;

    state_e                state_q;
    logic [LINES-1:0]      valid_q;
    logic [TAG_BITS-1:0]   tag_q [LINES];
    hart_mem_pkg::word_t   data_q [LINES];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic                  hit;
    hart_mem_pkg::word_t   line;
    hart_mem_pkg::word_t   merged;

    assign index = i_req_addr[2 +: INDEX_BITS];
    assign tag   = i_req_addr[INDEX_BITS+2 +: TAG_BITS];
    assign hit   = valid_q[index] && (tag_q[index] == tag);
    assign line  = data_q[index];

    // store bytes replace only the lanes enabled by the mask
    // the rest of the word comes from the line, which is always present
    // by the time the write goes out
    always_comb begin
        for (int b = 0; b < `BYTES_PER_WORD; b++) begin
            merged[8*b +: 8] = i_req_mask[b] ? i_req_wdata[8*b +: 8] : line[8*b +: 8];
        end
    end

    assign o_res_rdata = line;

    // a load hit is free, while every store costs at least the write
    always_comb begin
        case (state_q)
            S_IDLE:  o_busy = i_req_wen || (i_req_ren && !hit);
            S_DONE:  o_busy = 1'b0;
            default: o_busy = 1'b1;
        endcase
    end

    // the bus carries whole words, so a store always sends the merged word
    assign o_mem_ren   = (state_q == S_FILL_REQ);
    assign o_mem_wen   = (state_q == S_WRITE);
    assign o_mem_addr  = {i_req_addr[`XLEN-1:2], 2'b00};
    assign o_mem_wdata = merged;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    // a store on a miss fills first and comes back here
                    if (i_req_wen) begin
                        state_q <= hit ? S_WRITE : S_FILL_REQ;
                    end else if (i_req_ren && !hit) begin
                        state_q <= S_FILL_REQ;
                    end
                end
                S_FILL_REQ: begin
                    if (i_mem_ready) begin
                        state_q <= S_FILL_WAIT;
                    end
                end
                S_FILL_WAIT: begin
                    if (i_mem_valid) begin
                        valid_q[index] <= 1'b1;
                        state_q        <= S_IDLE;
                    end
                end
                S_WRITE: begin
                    if (i_mem_ready) begin
                        state_q <= S_DONE;
                    end
                end
                // single completion cycle with busy low, then back to lookup
                S_DONE:  state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // fill writes the fetched word, write-through updates the line on acceptance
    always_ff @(posedge i_clk) begin
        if ((state_q == S_FILL_WAIT) && i_mem_valid) begin
            tag_q[index]  <= tag;
            data_q[index] <= i_mem_rdata;
        end else if ((state_q == S_WRITE) && i_mem_ready) begin
            data_q[index] <= merged;
        end
    end

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                i_clk,
    input  logic                i_rst_n,
    // instruction cache, read only
    input  logic                i_ic_ren,
    input  hart_mem_pkg::word_t i_ic_addr,
    output logic                o_ic_ready,
    output logic                o_ic_valid,
    // data cache
    input  logic                i_dc_ren,
    input  logic                i_dc_wen,
    input  hart_mem_pkg::word_t i_dc_addr,
    input  hart_mem_pkg::word_t i_dc_wdata,
    output logic                o_dc_ready,
    output logic                o_dc_valid,
    // shared external bus
    output logic                o_mem_ren,
    output logic                o_mem_wen,
    output hart_mem_pkg::word_t o_mem_addr,
    output hart_mem_pkg::word_t o_mem_wdata,
    input  hart_mem_pkg::word_t i_mem_rdata,
    input  logic                i_mem_valid,
    input  logic                i_mem_ready
);
    hart_mem_pkg::bus_owner_e owner_q;
    hart_mem_pkg::bus_owner_e owner;
    logic                     ic_sel;
    logic                     dc_sel;

    // a free bus is granted in the same cycle, instruction side first
    always_comb begin
        owner = owner_q;
        if (owner_q == hart_mem_pkg::OWN_NONE) begin
            if (i_ic_ren) begin
                owner = hart_mem_pkg::OWN_ICACHE;
            end else if (i_dc_ren || i_dc_wen) begin
                owner = hart_mem_pkg::OWN_DCACHE;
            end
        end
    end

    assign ic_sel = (owner == hart_mem_pkg::OWN_ICACHE);
    assign dc_sel = (owner == hart_mem_pkg::OWN_DCACHE);

    // only the owner's strobes reach the bus
    // a waiting cache therefore cannot start a second transaction
    assign o_mem_ren   = (ic_sel && i_ic_ren) || (dc_sel && i_dc_ren);
    assign o_mem_wen   = dc_sel && i_dc_wen;
    assign o_mem_addr  = dc_sel ? i_dc_addr : i_ic_addr;
    assign o_mem_wdata = dc_sel ? i_dc_wdata : '0;

    // the cache without the bus sees ready and valid low
    assign o_ic_ready = ic_sel && i_mem_ready;
    assign o_ic_valid = ic_sel && i_mem_valid;
    assign o_dc_ready = dc_sel && i_mem_ready;
    assign o_dc_valid = dc_sel && i_mem_valid;

    // reads release the bus on valid, writes already on acceptance
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            owner_q <= hart_mem_pkg::OWN_NONE;
        end else if (o_mem_wen && i_mem_ready) begin
            owner_q <= hart_mem_pkg::OWN_NONE;
        end else if (i_mem_valid) begin
            owner_q <= hart_mem_pkg::OWN_NONE;
        end else begin
            owner_q <= owner;
        end
    end

endmodule

// File: source/lsu.sv
`timescale 1ns/1ps

module lsu (
    // load/store request, held by the requester until completion
    input  logic                     i_ls_read,
    input  logic                     i_ls_write,
    input  hart_mem_pkg::word_t      i_ls_addr,
    input  hart_mem_pkg::word_t      i_ls_wdata,
    input  hart_mem_pkg::ls_size_e   i_ls_size,
    input  logic                     i_ls_unsigned,
    // word-aligned request to the data cache
    input  hart_mem_pkg::word_t      i_dc_rdata,
    output logic                     o_dc_ren,
    output logic                     o_dc_wen,
    output hart_mem_pkg::word_t      o_dc_addr,
    output hart_mem_pkg::word_t      o_dc_wdata,
    output hart_mem_pkg::byte_mask_t o_dc_mask,
    // load result and trap
    output hart_mem_pkg::word_t      o_ls_rdata,
    output logic                     o_ls_trap
);
    logic [1:0]          offset;
    logic [4:0]          lane_shift;
    logic                misaligned;
    logic                sign_bit;
    hart_mem_pkg::word_t shifted;

    assign offset     = i_ls_addr[1:0];
    assign lane_shift = {offset, 3'b000};

    // halves need an even address and words a multiple of four
    assign misaligned = ((i_ls_size == hart_mem_pkg::LS_HALF) && offset[0]) ||
                        ((i_ls_size == hart_mem_pkg::LS_WORD) && (offset != 2'b00));

    // a misaligned access traps at once and the cache never sees it
    assign o_ls_trap = (i_ls_read || i_ls_write) && misaligned;
    assign o_dc_ren  = i_ls_read && !misaligned;
    assign o_dc_wen  = i_ls_write && !misaligned;
    assign o_dc_addr = {i_ls_addr[31:2], 2'b00};

    // store data moves up into its byte lane, the mask picks the lanes
    assign o_dc_wdata = i_ls_wdata << lane_shift;

    always_comb begin
        case (i_ls_size)
            hart_mem_pkg::LS_BYTE: o_dc_mask = 4'b0001 << offset;
            hart_mem_pkg::LS_HALF: o_dc_mask = 4'b0011 << offset;
            default:               o_dc_mask = 4'b1111;
        endcase
    end

    // load data comes down from its lane before extension
    assign shifted = i_dc_rdata >> lane_shift;

    always_comb begin
        sign_bit = 1'b0;
        case (i_ls_size)
            hart_mem_pkg::LS_BYTE: begin
                sign_bit   = !i_ls_unsigned && shifted[7];
                o_ls_rdata = {{24{sign_bit}}, shifted[7:0]};
            end
            hart_mem_pkg::LS_HALF: begin
                sign_bit   = !i_ls_unsigned && shifted[15];
                o_ls_rdata = {{16{sign_bit}}, shifted[15:0]};
            end
            default: o_ls_rdata = shifted;
        endcase
    end

endmodule

// File: source/hart_mem_sys.sv
`timescale 1ns/1ps

`include "hart_mem_consts.svh"

module hart_mem_sys (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    // fetch side
    input  hart_mem_pkg::word_t    i_fetch_addr,
    output hart_mem_pkg::word_t    o_fetch_inst,
    output logic                   o_fetch_busy,
    // load/store side
    input  logic                   i_ls_read,
    input  logic                   i_ls_write,
    input  hart_mem_pkg::word_t    i_ls_addr,
    input  hart_mem_pkg::word_t    i_ls_wdata,
    input  hart_mem_pkg::ls_size_e i_ls_size,
    input  logic                   i_ls_unsigned,
    output hart_mem_pkg::word_t    o_ls_rdata,
    output logic                   o_ls_trap,
    output logic                   o_ls_busy,
    // external memory bus
    output logic                   o_mem_ren,
    output logic                   o_mem_wen,
    output hart_mem_pkg::word_t    o_mem_addr,
    output hart_mem_pkg::word_t    o_mem_wdata,
    input  hart_mem_pkg::word_t    i_mem_rdata,
    input  logic                   i_mem_valid,
    input  logic                   i_mem_ready
);
    // icache to arbiter
    logic ic_mem_ren, ic_mem_ready, ic_mem_valid;
    hart_mem_pkg::word_t ic_mem_addr;
    // dcache to arbiter
    logic dc_mem_ren, dc_mem_wen, dc_mem_ready, dc_mem_valid;
    hart_mem_pkg::word_t dc_mem_addr, dc_mem_wdata;
    // lsu to dcache
    logic dc_ren, dc_wen;
    hart_mem_pkg::word_t dc_addr, dc_wdata, dc_rdata;
    hart_mem_pkg::byte_mask_t dc_mask;

    icache #(.INDEX_BITS(`ICACHE_INDEX_BITS)) u_icache (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_addr(i_fetch_addr),
        .o_inst(o_fetch_inst), .o_busy(o_fetch_busy),
        .o_mem_ren(ic_mem_ren), .o_mem_addr(ic_mem_addr), .i_mem_rdata(i_mem_rdata),
        .i_mem_ready(ic_mem_ready), .i_mem_valid(ic_mem_valid)
    );

    // the load/store busy is the data cache busy, a trap never reaches it
    dcache #(.INDEX_BITS(`DCACHE_INDEX_BITS)) u_dcache (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_req_ren(dc_ren), .i_req_wen(dc_wen), .i_req_addr(dc_addr),
        .i_req_wdata(dc_wdata), .i_req_mask(dc_mask),
        .o_res_rdata(dc_rdata), .o_busy(o_ls_busy),
        .o_mem_ren(dc_mem_ren), .o_mem_wen(dc_mem_wen), .o_mem_addr(dc_mem_addr),
        .o_mem_wdata(dc_mem_wdata), .i_mem_rdata(i_mem_rdata),
        .i_mem_ready(dc_mem_ready), .i_mem_valid(dc_mem_valid)
    );

    lsu u_lsu (
        .i_ls_read(i_ls_read), .i_ls_write(i_ls_write), .i_ls_addr(i_ls_addr),
        .i_ls_wdata(i_ls_wdata), .i_ls_size(i_ls_size), .i_ls_unsigned(i_ls_unsigned),
        .i_dc_rdata(dc_rdata), .o_dc_ren(dc_ren), .o_dc_wen(dc_wen), .o_dc_addr(dc_addr),
        .o_dc_wdata(dc_wdata), .o_dc_mask(dc_mask),
        .o_ls_rdata(o_ls_rdata), .o_ls_trap(o_ls_trap)
    );

    mem_arbiter u_arbiter (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_ic_ren(ic_mem_ren), .i_ic_addr(ic_mem_addr),
        .o_ic_ready(ic_mem_ready), .o_ic_valid(ic_mem_valid),
        .i_dc_ren(dc_mem_ren), .i_dc_wen(dc_mem_wen), .i_dc_addr(dc_mem_addr),
        .i_dc_wdata(dc_mem_wdata), .o_dc_ready(dc_mem_ready), .o_dc_valid(dc_mem_valid),
        .o_mem_ren(o_mem_ren), .o_mem_wen(o_mem_wen), .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata),
        .i_mem_valid(i_mem_valid), .i_mem_ready(i_mem_ready)
    );

endmodule

// File: test/hart_mem_asserts.sv
`timescale 1ns/1ps

module hart_mem_asserts (
    input logic                i_clk,
    input logic                i_rst_n,
    input logic                i_mem_ren,
    input logic                i_mem_wen,
    input hart_mem_pkg::word_t i_mem_addr,
    input hart_mem_pkg::word_t i_mem_wdata,
    input logic                i_mem_ready,
    input logic                i_mem_valid
);
    // high from an accepted read until its data comes back
    logic read_pending_q;

    // number of protocol assertions that have failed so far
    int fail_count = 0;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            read_pending_q <= 1'b0;
        end else if (i_mem_ren && i_mem_ready) begin
            read_pending_q <= 1'b1;
        end else if (i_mem_valid) begin
            read_pending_q <= 1'b0;
        end
    end

    // a single bus cannot read and write in the same cycle
    a_no_rw_overlap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_mem_ren && i_mem_wen))
        else begin
            $error("bus read and write strobes are high together");
            fail_count++;
        end

    // a read that is not yet accepted keeps its strobe and address
    a_ren_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_mem_ren && !i_mem_ready) |=> (i_mem_ren && $stable(i_mem_addr)))
        else begin
            $error("read request changed before it was accepted");
            fail_count++;
        end

    // same for a write, whose data must not move either
    a_wen_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_mem_wen && !i_mem_ready) |=> (i_mem_wen && $stable(i_mem_addr)
        && $stable(i_mem_wdata)))
        else begin
            $error("write request changed before it was accepted");
            fail_count++;
        end

    // only one transaction may be outstanding
    a_one_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        read_pending_q |-> !(i_mem_ren || i_mem_wen))
        else begin
            $error("new bus request while a read still waits for valid");
            fail_count++;
        end

endmodule

bind hart_mem_sys hart_mem_asserts u_asserts (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_mem_ren(o_mem_ren), .i_mem_wen(o_mem_wen),
    .i_mem_addr(o_mem_addr), .i_mem_wdata(o_mem_wdata), .i_mem_ready(i_mem_ready),
    .i_mem_valid(i_mem_valid)
);

// File: test/tb_hart_mem_sys.sv
`timescale 1ns/1ps

module tb_hart_mem_sys;
    logic i_clk, i_rst_n, i_ls_read, i_ls_write, i_ls_unsigned;
    logic i_mem_valid, i_mem_ready, o_fetch_busy, o_ls_trap, o_ls_busy;
    logic o_mem_ren, o_mem_wen;
    hart_mem_pkg::word_t i_fetch_addr, i_ls_addr, i_ls_wdata, i_mem_rdata;
    hart_mem_pkg::word_t o_fetch_inst, o_ls_rdata, o_mem_addr, o_mem_wdata;
    hart_mem_pkg::ls_size_e i_ls_size;
    // memory model of 256 words, indexed by address bits 9:2
    hart_mem_pkg::word_t mem [256];
    hart_mem_pkg::word_t acc_addr, acc_wdata, rd_addr, race_addr;
    hart_mem_pkg::word_t exp_inst, exp_rdata, exp_wdata, exp_waddr;
    integer seed;
    int n_req, cycles, rd_cnt;
    logic rd_acc, wr_acc, rd_pend, race_armed, rep_chk, misaligned;

    hart_mem_sys uut (.*);

    always #5 i_clk = ~i_clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // load value as the size and signedness rules define it
    function automatic hart_mem_pkg::word_t load_value(hart_mem_pkg::word_t w,
            logic [1:0] off, hart_mem_pkg::ls_size_e sz, logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        if (sz == hart_mem_pkg::LS_BYTE) return uns ? {24'd0, b} : {{24{b[7]}}, b};
        if (sz == hart_mem_pkg::LS_HALF) return uns ? {16'd0, h} : {{16{h[15]}}, h};
        return w;
    endfunction

    // the old word with only the stored lanes replaced
    function automatic hart_mem_pkg::word_t store_value(hart_mem_pkg::word_t old,
            hart_mem_pkg::word_t wd, logic [1:0] off, hart_mem_pkg::ls_size_e sz);
        hart_mem_pkg::word_t r;
        r = old;
        if (sz == hart_mem_pkg::LS_BYTE) r[8*off +: 8] = wd[7:0];
        else if (sz == hart_mem_pkg::LS_HALF) r[8*off +: 16] = wd[15:0];
        else r = wd;
        return r;
    endfunction

    assign exp_inst  = mem[i_fetch_addr[9:2]];
    assign exp_rdata = load_value(mem[i_ls_addr[9:2]], i_ls_addr[1:0], i_ls_size, i_ls_unsigned);
    assign exp_wdata = store_value(mem[i_ls_addr[9:2]], i_ls_wdata, i_ls_addr[1:0], i_ls_size);
    // the bus carries only word addresses
    assign exp_waddr = {i_ls_addr[31:2], 2'b00};
    assign misaligned = ((i_ls_size == hart_mem_pkg::LS_HALF) && i_ls_addr[0]) ||
                        ((i_ls_size == hart_mem_pkg::LS_WORD) && (i_ls_addr[1:0] != 2'b00));

    a_fetch: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_fetch_busy |-> o_fetch_inst == exp_inst)
        else fail_now($sformatf("MISMATCH o_fetch_inst got %h expected %h",
            $sampled(o_fetch_inst), $sampled(exp_inst)));
    a_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ls_read && !o_ls_busy && !o_ls_trap) |-> o_ls_rdata == exp_rdata)
        else fail_now($sformatf("MISMATCH o_ls_rdata got %h expected %h",
            $sampled(o_ls_rdata), $sampled(exp_rdata)));
    a_store: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_mem_wen && i_mem_ready) |-> o_mem_wdata == exp_wdata)
        else fail_now($sformatf("MISMATCH o_mem_wdata got %h expected %h",
            $sampled(o_mem_wdata), $sampled(exp_wdata)));
    a_store_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_mem_wen && i_mem_ready) |-> o_mem_addr == exp_waddr)
        else fail_now($sformatf("MISMATCH o_mem_addr got %h expected %h",
            $sampled(o_mem_addr), $sampled(exp_waddr)));
    a_trap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ((i_ls_read || i_ls_write) && misaligned) |-> (o_ls_trap && !o_ls_busy && !o_mem_wen))
        else fail_now("misaligned request did not trap at once or reached the bus");
    a_race: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (race_armed && o_mem_ren && i_mem_ready) |-> o_mem_addr == race_addr)
        else fail_now($sformatf("MISMATCH o_mem_addr got %h expected %h",
            $sampled(o_mem_addr), $sampled(race_addr)));
    a_repeat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        rep_chk |-> !(o_fetch_busy || o_ls_busy || o_mem_ren || o_mem_wen))
        else fail_now("repeated fetch or load address did not hit in the same cycle");

    // protocol errors seen by the bound checker
    always @(negedge i_clk) begin
        if (uut.u_asserts.fail_count != 0) begin
            fail_now("bus protocol assertion failed in the bound checker");
        end
    end

    // the handshake signals have settled by the falling edge and are recorded there
    always @(negedge i_clk) begin
        rd_acc    = o_mem_ren && i_mem_ready;
        wr_acc    = o_mem_wen && i_mem_ready;
        acc_addr  = o_mem_addr;
        acc_wdata = o_mem_wdata;
    end

    // the model follows reset as the DUT samples it at the rising edge
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            #1;
            i_mem_valid = 1'b0;
            i_mem_ready = 1'b0;
            rd_pend     = 1'b0;
        end else begin
            #1;
            if (wr_acc) mem[acc_addr[9:2]] = acc_wdata;
            if (rd_acc || wr_acc) race_armed = 1'b0;
            // read data comes back 1 to 4 cycles after acceptance
            if (rd_acc) begin
                rd_pend = 1'b1;
                rd_addr = acc_addr;
                rd_cnt  = 1 + ($random(seed) & 3);
            end
            i_mem_valid = 1'b0;
            if (rd_pend) begin
                rd_cnt = rd_cnt - 1;
                if (rd_cnt == 0) begin
                    i_mem_valid = 1'b1;
                    i_mem_rdata = mem[rd_addr[9:2]];
                    rd_pend     = 1'b0;
                end
            end
            i_mem_ready = $random(seed) & 1;
        end
    end

    // each request may take up to 200 cycles on top of a fixed allowance
    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > 200 * n_req + 1000) fail_now("watchdog timeout, the DUT stopped responding");
    end

    task automatic fetch_at(input hart_mem_pkg::word_t a);
        @(posedge i_clk);
        #1 i_fetch_addr = a;
        n_req = n_req + 1;
        @(negedge i_clk);
        while (o_fetch_busy) @(negedge i_clk);
    endtask

    task automatic access_data(input logic rd, input logic wr, input hart_mem_pkg::word_t a,
            input hart_mem_pkg::word_t wd, input int sz, input logic uns);
        @(posedge i_clk);
        #1;
        i_ls_read     = rd;
        i_ls_write    = wr;
        i_ls_addr     = a;
        i_ls_wdata    = wd;
        i_ls_size     = hart_mem_pkg::ls_size_e'(sz);
        i_ls_unsigned = uns;
        n_req = n_req + 1;
        // the request completes in the first cycle with busy low
        @(negedge i_clk);
        while (o_ls_busy) @(negedge i_clk);
        @(posedge i_clk);
        #1;
        i_ls_read  = 1'b0;
        i_ls_write = 1'b0;
    endtask

    initial begin
        hart_mem_pkg::word_t a;
        int sz;
        logic [7:0] k;
        seed = 32'h73b751dd;
        i_clk = 0;
        i_rst_n = 0;
        i_fetch_addr = '0;
        i_ls_read = 0;
        i_ls_write = 0;
        i_ls_addr = '0;
        i_ls_wdata = '0;
        i_ls_size = hart_mem_pkg::LS_WORD;
        i_ls_unsigned = 0;
        i_mem_rdata = '0;
        i_mem_valid = 0;
        i_mem_ready = 0;
        n_req = 0;
        cycles = 0;
        race_armed = 0;
        rep_chk = 0;
        race_addr = '0;
        for (int i = 0; i < 256; i++) begin
            k = i;
            mem[i] = {k ^ 8'h5a, ~k, k * 8'd37, k + 8'hc3};
        end
        repeat (4) @(posedge i_clk);
        #1 i_rst_n = 1;
        // forty fetches in the code region evict lines of the instruction cache
        for (int i = 0; i < 40; i++) fetch_at(i * 4);
        // loads of every size at legal offsets alternate between signed and unsigned
        for (int i = 0; i < 24; i++) begin
            sz = ($random(seed) & 32'h7fff_ffff) % 3;
            a  = 32'h200 + ($random(seed) & 32'h1ff);
            if (sz == 1) a[0] = 1'b0;
            if (sz == 2) a[1:0] = 2'b00;
            access_data(1, 0, a, '0, sz, i[0]);
        end
        // each store is read back as a whole word
        for (int i = 0; i < 16; i++) begin
            sz = ($random(seed) & 32'h7fff_ffff) % 3;
            a  = 32'h200 + ($random(seed) & 32'h1ff);
            if (sz == 1) a[0] = 1'b0;
            if (sz == 2) a[1:0] = 2'b00;
            access_data(0, 1, a, $random(seed), sz, 0);
            access_data(1, 0, {a[31:2], 2'b00}, '0, 2, 0);
        end
        // misaligned half and word requests must trap without reaching the bus
        access_data(1, 0, 32'h301, '0, 1, 0);
        access_data(0, 1, 32'h302, 32'hdeadbeef, 2, 0);
        access_data(0, 1, 32'h303, 32'h1234, 1, 0);
        access_data(1, 0, 32'h205, '0, 2, 1);
        // fetch miss and load miss raised in the same cycle
        @(posedge i_clk);
        #1;
        race_addr = 32'h0000_00f4;
        race_armed = 1;
        i_fetch_addr = race_addr;
        i_ls_addr = 32'h0000_00fc;
        i_ls_size = hart_mem_pkg::LS_WORD;
        i_ls_read = 1;
        n_req = n_req + 2;
        @(negedge i_clk);
        while (o_fetch_busy || o_ls_busy) @(negedge i_clk);
        @(posedge i_clk);
        #1 i_ls_read = 0;
        // the same addresses again must hit without touching the bus
        @(posedge i_clk);
        #1;
        i_ls_read = 1;
        rep_chk = 1;
        @(posedge i_clk);
        #1;
        rep_chk = 0;
        i_ls_read = 0;
        repeat (4) @(posedge i_clk);
        $display("TEST OK");
        $finish;
    end

endmodule

// File: compile.f
+incdir+source
source/hart_mem_pkg.sv
source/icache.sv
source/dcache.sv
source/mem_arbiter.sv
source/lsu.sv
source/hart_mem_sys.sv
test/hart_mem_asserts.sv
test/tb_hart_mem_sys.sv

// File: Bender.yml
package:
  name: hart_mem_sys

export_include_dirs:
  - source

sources:
  - source/hart_mem_pkg.sv
  - source/icache.sv
  - source/dcache.sv
  - source/mem_arbiter.sv
  - source/lsu.sv
  - source/hart_mem_sys.sv
  - target: test
    files:
      - test/hart_mem_asserts.sv
      - test/tb_hart_mem_sys.sv
